// File: logic/csr_op_pkg.sv
// CSR operation encodings
package csr_op_pkg;

    // op field as driven by the pipeline
    typedef enum logic [2:0] {
        OP_EXCEPTION = 3'b000,
        OP_MRET      = 3'b001,
        OP_NOP       = 3'b011,
        OP_CSRRW     = 3'b101,
        OP_CSRRS     = 3'b110,
        OP_CSRRC     = 3'b111
    } csr_op_e;

    // source for the registered read value
    typedef enum logic [2:0] {
        RSEL_NONE,
        RSEL_HANDLER,
        RSEL_MSTATUS,
        RSEL_MIE,
        RSEL_MEPC,
        RSEL_MCAUSE,
        RSEL_MIP
    } csr_rsel_e;

endpackage

// File: logic/csr_map_pkg.sv
// Machine-mode CSR map
package csr_map_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [3:0]  exc_code_t;

    // interrupt flag on top, exception code below
    typedef logic [4:0]  trap_cause_t;

    // register addresses
    parameter csr_addr_t ADDR_MSTATUS = 12'h300;
    parameter csr_addr_t ADDR_MIE     = 12'h304;
    parameter csr_addr_t ADDR_MEPC    = 12'h341;
    parameter csr_addr_t ADDR_MCAUSE  = 12'h342;
    parameter csr_addr_t ADDR_MIP     = 12'h344;

    // mstatus fields
    parameter int BIT_MIE  = 3;
    parameter int BIT_MPIE = 7;

    // mie and mip share these positions
    parameter int BIT_SOFT = 3;
    parameter int BIT_EXT  = 11;

    // interrupt flag in mcause
    parameter int BIT_INTR = 31;

    // causes that retire a pending interrupt
    parameter trap_cause_t CAUSE_SW_IRQ  = 5'b10011;
    parameter trap_cause_t CAUSE_EXT_IRQ = 5'b11011;

endpackage

// File: logic/csr_decode.sv
// CSR op and address decoder
`timescale 1ns/1ps

module csr_decode import csr_op_pkg::*, csr_map_pkg::*; (
    input  logic      available_i,
    input  logic      is_write_stage_i,
    input  csr_op_e   op_i,
    input  csr_addr_t addr_i,
    input  csr_data_t write_value_i,
    output logic      trap_read_o,
    output logic      mret_read_o,
    output logic      trap_commit_o,
    output logic      mret_commit_o,
    output logic      wr_mstatus_o,
    output logic      wr_mie_o,
    output logic      wr_mepc_o,
    output logic      wr_mcause_o,
    output logic      wr_mip_o,
    output csr_rsel_e read_sel_o,
    output csr_data_t set_mask_o,
    output csr_data_t keep_mask_o,
    output logic      fault_req_o
);

    logic op_exc;
    logic op_mret;
    logic op_csr;
    logic op_valid;
    logic hit_mstatus;
    logic hit_mie;
    logic hit_mepc;
    logic hit_mcause;
    logic hit_mip;
    logic addr_mapped;
    logic rd_stage;
    logic wr_stage;
    logic csr_ok;

    // new bit = set | (keep & old)
    always_comb begin
        op_exc      = 1'b0;
        op_mret     = 1'b0;
        op_csr      = 1'b0;
        op_valid    = 1'b1;
        set_mask_o  = '0;
        keep_mask_o = '0;
        case (op_i)
            OP_EXCEPTION: op_exc = 1'b1;
            OP_MRET:      op_mret = 1'b1;
            OP_NOP:       op_valid = 1'b1;
            OP_CSRRW: begin
                op_csr     = 1'b1;
                set_mask_o = write_value_i;
            end
            OP_CSRRS: begin
                op_csr      = 1'b1;
                set_mask_o  = write_value_i;
                keep_mask_o = '1;
            end
            OP_CSRRC: begin
                op_csr      = 1'b1;
                keep_mask_o = ~write_value_i;
            end
            default: op_valid = 1'b0;
        endcase
    end

    assign hit_mstatus = (addr_i == ADDR_MSTATUS);
    assign hit_mie     = (addr_i == ADDR_MIE);
    assign hit_mepc    = (addr_i == ADDR_MEPC);
    assign hit_mcause  = (addr_i == ADDR_MCAUSE);
    assign hit_mip     = (addr_i == ADDR_MIP);
    assign addr_mapped = hit_mstatus | hit_mie | hit_mepc | hit_mcause | hit_mip;

    assign rd_stage = available_i & ~is_write_stage_i;
    assign wr_stage = available_i & is_write_stage_i;
    assign csr_ok   = op_csr & addr_mapped;

    assign trap_read_o   = rd_stage & op_exc;
    assign mret_read_o   = rd_stage & op_mret;
    assign trap_commit_o = wr_stage & op_exc;
    assign mret_commit_o = wr_stage & op_mret;
    assign wr_mstatus_o  = wr_stage & csr_ok & hit_mstatus;
    assign wr_mie_o      = wr_stage & csr_ok & hit_mie;
    assign wr_mepc_o     = wr_stage & csr_ok & hit_mepc;
    assign wr_mcause_o   = wr_stage & csr_ok & hit_mcause;
    assign wr_mip_o      = wr_stage & csr_ok & hit_mip;

    // bad op, or csr op outside the map
    assign fault_req_o = available_i & (~op_valid | (op_csr & ~addr_mapped));

    always_comb begin
        read_sel_o = RSEL_NONE;
        if (rd_stage) begin
            if (op_exc) begin
                read_sel_o = RSEL_HANDLER;
            end else if (op_mret) begin
                read_sel_o = RSEL_MEPC;
            end else if (csr_ok) begin
                if (hit_mstatus) begin
                    read_sel_o = RSEL_MSTATUS;
                end else if (hit_mie) begin
                    read_sel_o = RSEL_MIE;
                end else if (hit_mepc) begin
                    read_sel_o = RSEL_MEPC;
                end else if (hit_mcause) begin
                    read_sel_o = RSEL_MCAUSE;
                end else begin
                    read_sel_o = RSEL_MIP;
                end
            end
        end
    end

endmodule

// File: logic/csr_trap_state.sv
// Trap state registers
`timescale 1ns/1ps

module csr_trap_state import csr_map_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_n_i,
    input  logic        trap_read_i,
    input  logic        mret_read_i,
    input  logic        trap_commit_i,
    input  logic        mret_commit_i,
    input  logic        wr_mstatus_i,
    input  logic        wr_mepc_i,
    input  logic        wr_mcause_i,
    input  csr_data_t   set_mask_i,
    input  csr_data_t   keep_mask_i,
    input  trap_cause_t cause_i,
    input  csr_data_t   trap_pc_i,
    output logic        global_ie_o,
    output logic        mpie_o,
    output csr_data_t   mepc_o,
    output logic        mcause_intr_o,
    output exc_code_t   mcause_code_o
);

    logic      mie_q;
    logic      mpie_q;
    csr_data_t mepc_q;
    logic      mcause_intr_q;
    exc_code_t mcause_code_q;

    // carries MIE or MPIE from the read stage to the write stage
    logic      saved_ie_q;

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            mie_q         <= 1'b0;
            mpie_q        <= 1'b0;
            mepc_q        <= '0;
            mcause_intr_q <= 1'b0;
            mcause_code_q <= '0;
            saved_ie_q    <= 1'b0;
        end else begin
            if (trap_read_i) begin
                saved_ie_q <= mie_q;
            end else if (mret_read_i) begin
                saved_ie_q <= mpie_q;
            end

            if (trap_commit_i) begin
                mepc_q        <= {trap_pc_i[31:2], 2'b00};
                mcause_intr_q <= cause_i[4];
                mcause_code_q <= cause_i[3:0];
                mpie_q        <= saved_ie_q;
                mie_q         <= 1'b0;
            end else if (mret_commit_i) begin
                mie_q <= saved_ie_q;
            end else if (wr_mstatus_i) begin
                mie_q  <= set_mask_i[BIT_MIE] | (keep_mask_i[BIT_MIE] & mie_q);
                mpie_q <= set_mask_i[BIT_MPIE] | (keep_mask_i[BIT_MPIE] & mpie_q);
            end else if (wr_mepc_i) begin
                // pc is word aligned
                mepc_q <= {set_mask_i[31:2] | (keep_mask_i[31:2] & mepc_q[31:2]), 2'b00};
            end else if (wr_mcause_i) begin
                mcause_intr_q <= set_mask_i[BIT_INTR] |
                                 (keep_mask_i[BIT_INTR] & mcause_intr_q);
                mcause_code_q <= set_mask_i[3:0] | (keep_mask_i[3:0] & mcause_code_q);
            end
        end
    end

    assign global_ie_o   = mie_q;
    assign mpie_o        = mpie_q;
    assign mepc_o        = mepc_q;
    assign mcause_intr_o = mcause_intr_q;
    assign mcause_code_o = mcause_code_q;

endmodule

// File: logic/csr_irq_state.sv
// Interrupt enable and pending state
`timescale 1ns/1ps

module csr_irq_state import csr_map_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_n_i,
    input  logic        ext_int_i,
    input  logic        global_ie_i,
    input  logic        trap_commit_i,
    input  trap_cause_t cause_i,
    input  logic        wr_mie_i,
    input  logic        wr_mip_i,
    input  csr_data_t   set_mask_i,
    input  csr_data_t   keep_mask_i,
    output logic        meie_o,
    output logic        msie_o,
    output logic        meip_o,
    output logic        msip_o,
    output logic        ext_int_pending_o,
    output logic        sw_int_pending_o
);

    logic meie_q;
    logic msie_q;
    logic meip_q;
    logic msip_q;
    logic ext_pend_q;
    logic sw_pend_q;

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            meie_q     <= 1'b0;
            msie_q     <= 1'b0;
            meip_q     <= 1'b0;
            msip_q     <= 1'b0;
            ext_pend_q <= 1'b0;
            sw_pend_q  <= 1'b0;
        end else begin
            // pending outputs see the state from before this edge
            ext_pend_q <= meip_q & meie_q & global_ie_i;
            sw_pend_q  <= msip_q & msie_q & global_ie_i;

            if (trap_commit_i) begin
                // software interrupt is retired first
                if (cause_i == CAUSE_SW_IRQ && msip_q) begin
                    msip_q <= 1'b0;
                end else if (cause_i == CAUSE_EXT_IRQ && meip_q) begin
                    meip_q <= 1'b0;
                end
            end

            if (wr_mie_i) begin
                meie_q <= set_mask_i[BIT_EXT] | (keep_mask_i[BIT_EXT] & meie_q);
                msie_q <= set_mask_i[BIT_SOFT] | (keep_mask_i[BIT_SOFT] & msie_q);
            end

            if (wr_mip_i) begin
                meip_q <= set_mask_i[BIT_EXT] | (keep_mask_i[BIT_EXT] & meip_q);
                msip_q <= set_mask_i[BIT_SOFT] | (keep_mask_i[BIT_SOFT] & msip_q);
            end

            // the external line wins over any clear
            if (ext_int_i) begin
                meip_q <= 1'b1;
            end
        end
    end

    assign meie_o            = meie_q;
    assign msie_o            = msie_q;
    assign meip_o            = meip_q;
    assign msip_o            = msip_q;
    assign ext_int_pending_o = ext_pend_q;
    assign sw_int_pending_o  = sw_pend_q;

endmodule

// File: logic/csr_response.sv
// Read value and fault response
`timescale 1ns/1ps

module csr_response import csr_op_pkg::*, csr_map_pkg::*; #(
    parameter csr_data_t HANDLER_ADDR = 32'h0000_0010
) (
    input  logic      clk_i,
    input  logic      reset_n_i,
    input  csr_rsel_e read_sel_i,
    input  logic      fault_req_i,
    input  logic      global_ie_i,
    input  logic      mpie_i,
    input  csr_data_t mepc_i,
    input  logic      mcause_intr_i,
    input  exc_code_t mcause_code_i,
    input  logic      meie_i,
    input  logic      msie_i,
    input  logic      meip_i,
    input  logic      msip_i,
    output csr_data_t read_value_o,
    output logic      fault_o
);

    csr_data_t rd_word;
    csr_data_t read_value_q;
    logic      fault_q;

    // architectural layout, unused bits read zero
    always_comb begin
        rd_word = '0;
        case (read_sel_i)
            RSEL_HANDLER: rd_word = HANDLER_ADDR;
            RSEL_MSTATUS: begin
                rd_word[BIT_MIE]  = global_ie_i;
                rd_word[BIT_MPIE] = mpie_i;
            end
            RSEL_MIE: begin
                rd_word[BIT_EXT]  = meie_i;
                rd_word[BIT_SOFT] = msie_i;
            end
            RSEL_MEPC: rd_word = mepc_i;
            RSEL_MCAUSE: begin
                rd_word[BIT_INTR] = mcause_intr_i;
                rd_word[3:0]      = mcause_code_i;
            end
            RSEL_MIP: begin
                rd_word[BIT_EXT]  = meip_i;
                rd_word[BIT_SOFT] = msip_i;
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            read_value_q <= '0;
            fault_q      <= 1'b0;
        end else begin
            // hold the last value when nothing is read
            if (read_sel_i != RSEL_NONE) begin
                read_value_q <= rd_word;
            end
            fault_q <= fault_req_i;
        end
    end

    assign read_value_o = read_value_q;
    assign fault_o      = fault_q;

endmodule

// File: logic/csr_top.sv
// Machine-mode CSR unit
`timescale 1ns/1ps

module csr_top import csr_op_pkg::*, csr_map_pkg::*; #(
    parameter csr_data_t HANDLER_ADDR = 32'h0000_0010
) (
    input  logic       clk_i,
    input  logic       reset_n_i,
    input  logic       available_i,
    input  logic       is_write_stage_i,
    input  logic       ext_int_i,
    input  logic [2:0] op_i,
    input  csr_addr_t  addr_exception_i,
    input  csr_data_t  write_value_i,
    output csr_data_t  read_value_o,
    output logic       ext_int_pending_o,
    output logic       sw_int_pending_o,
    output logic       fault_o
);

    logic        trap_read;
    logic        mret_read;
    logic        trap_commit;
    logic        mret_commit;
    logic        wr_mstatus;
    logic        wr_mie;
    logic        wr_mepc;
    logic        wr_mcause;
    logic        wr_mip;
    csr_rsel_e   read_sel;
    csr_data_t   set_mask;
    csr_data_t   keep_mask;
    logic        fault_req;
    trap_cause_t cause;
    logic        global_ie;
    logic        mpie;
    csr_data_t   mepc;
    logic        mcause_intr;
    exc_code_t   mcause_code;
    logic        meie;
    logic        msie;
    logic        meip;
    logic        msip;

    // trap cause rides on the low address bits
    assign cause = addr_exception_i[4:0];

    csr_decode decode_i (
        .available_i      (available_i),
        .is_write_stage_i (is_write_stage_i),
        .op_i             (csr_op_e'(op_i)),
        .addr_i           (addr_exception_i),
        .write_value_i    (write_value_i),
        .trap_read_o      (trap_read),
        .mret_read_o      (mret_read),
        .trap_commit_o    (trap_commit),
        .mret_commit_o    (mret_commit),
        .wr_mstatus_o     (wr_mstatus),
        .wr_mie_o         (wr_mie),
        .wr_mepc_o        (wr_mepc),
        .wr_mcause_o      (wr_mcause),
        .wr_mip_o         (wr_mip),
        .read_sel_o       (read_sel),
        .set_mask_o       (set_mask),
        .keep_mask_o      (keep_mask),
        .fault_req_o      (fault_req)
    );

    csr_trap_state trap_state_i (
        .clk_i         (clk_i),
        .reset_n_i     (reset_n_i),
        .trap_read_i   (trap_read),
        .mret_read_i   (mret_read),
        .trap_commit_i (trap_commit),
        .mret_commit_i (mret_commit),
        .wr_mstatus_i  (wr_mstatus),
        .wr_mepc_i     (wr_mepc),
        .wr_mcause_i   (wr_mcause),
        .set_mask_i    (set_mask),
        .keep_mask_i   (keep_mask),
        .cause_i       (cause),
        .trap_pc_i     (write_value_i),
        .global_ie_o   (global_ie),
        .mpie_o        (mpie),
        .mepc_o        (mepc),
        .mcause_intr_o (mcause_intr),
        .mcause_code_o (mcause_code)
    );

    csr_irq_state irq_state_i (
        .clk_i             (clk_i),
        .reset_n_i         (reset_n_i),
        .ext_int_i         (ext_int_i),
        .global_ie_i       (global_ie),
        .trap_commit_i     (trap_commit),
        .cause_i           (cause),
        .wr_mie_i          (wr_mie),
        .wr_mip_i          (wr_mip),
        .set_mask_i        (set_mask),
        .keep_mask_i       (keep_mask),
        .meie_o            (meie),
        .msie_o            (msie),
        .meip_o            (meip),
        .msip_o            (msip),
        .ext_int_pending_o (ext_int_pending_o),
        .sw_int_pending_o  (sw_int_pending_o)
    );

    csr_response #(
        .HANDLER_ADDR (HANDLER_ADDR)
    ) response_i (
        .clk_i         (clk_i),
        .reset_n_i     (reset_n_i),
        .read_sel_i    (read_sel),
        .fault_req_i   (fault_req),
        .global_ie_i   (global_ie),
        .mpie_i        (mpie),
        .mepc_i        (mepc),
        .mcause_intr_i (mcause_intr),
        .mcause_code_i (mcause_code),
        .meie_i        (meie),
        .msie_i        (msie),
        .meip_i        (meip),
        .msip_i        (msip),
        .read_value_o  (read_value_o),
        .fault_o       (fault_o)
    );

endmodule

// File: bench/tb_csr_top.sv
// CSR unit testbench
`timescale 1ns/1ps

module tb_csr_top import csr_map_pkg::*; ();

    localparam csr_data_t HANDLER      = 32'h0000_0010;
    localparam int        MAX_ROWS     = 128;
    localparam int        RUN_LIMIT_NS = 20000;

    // op codes as the pipeline drives them
    localparam logic [2:0] OPC_EXC  = 3'b000;
    localparam logic [2:0] OPC_MRET = 3'b001;
    localparam logic [2:0] OPC_NOP  = 3'b011;
    localparam logic [2:0] OPC_RW   = 3'b101;
    localparam logic [2:0] OPC_RS   = 3'b110;
    localparam logic [2:0] OPC_RC   = 3'b111;

    typedef struct packed {
        logic [3:0] tst;
        logic       avail;
        logic       wstage;
        logic [2:0] op;
        csr_addr_t  addr;
        csr_data_t  wv;
        logic       ext;
        logic       chk;
        csr_data_t  exp_rd;
        logic       exp_fault;
        logic       exp_ext;
        logic       exp_sw;
    } row_t;

    logic       clk_i;
    logic       reset_n_i;
    logic       available_i;
    logic       is_write_stage_i;
    logic       ext_int_i;
    logic [2:0] op_i;
    csr_addr_t  addr_exception_i;
    csr_data_t  write_value_i;
    csr_data_t  read_value_o;
    logic       ext_int_pending_o;
    logic       sw_int_pending_o;
    logic       fault_o;

    row_t        table_q [MAX_ROWS];
    int          n_rows;
    int          cur_row;
    logic [31:0] lfsr;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    string       test_names [6];

    // reference model state
    logic      m_mie;
    logic      m_mpie;
    logic      m_saved;
    csr_data_t m_mepc;
    logic      m_mcause_intr;
    logic [3:0] m_code;
    logic      m_meie;
    logic      m_msie;
    logic      m_meip;
    logic      m_msip;
    csr_data_t m_rd;
    logic      m_fault;
    logic      m_ext_pend;
    logic      m_sw_pend;

    csr_top dut_i (
        .clk_i             (clk_i),
        .reset_n_i         (reset_n_i),
        .available_i       (available_i),
        .is_write_stage_i  (is_write_stage_i),
        .ext_int_i         (ext_int_i),
        .op_i              (op_i),
        .addr_exception_i  (addr_exception_i),
        .write_value_i     (write_value_i),
        .read_value_o      (read_value_o),
        .ext_int_pending_o (ext_int_pending_o),
        .sw_int_pending_o  (sw_int_pending_o),
        .fault_o           (fault_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        #(RUN_LIMIT_NS);
        $display("run limit reached before the table finished");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic csr_data_t rand_word();
        csr_data_t w;
        int        i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic add_row(input logic [3:0] tst, input logic avail, input logic wstage,
                           input logic [2:0] op, input csr_addr_t addr, input csr_data_t wv,
                           input logic ext, input logic chk);
        table_q[n_rows] = '0;
        table_q[n_rows].tst = tst;
        table_q[n_rows].avail = avail;
        table_q[n_rows].wstage = wstage;
        table_q[n_rows].op = op;
        table_q[n_rows].addr = addr;
        table_q[n_rows].wv = wv;
        table_q[n_rows].ext = ext;
        table_q[n_rows].chk = chk;
        n_rows++;
    endtask

    // read stage then write stage
    task automatic csr_op(input logic [3:0] tst, input logic [2:0] op, input csr_addr_t addr,
                          input csr_data_t wv);
        add_row(tst, 1'b1, 1'b0, op, addr, wv, 1'b0, 1'b1);
        add_row(tst, 1'b1, 1'b1, op, addr, wv, 1'b0, 1'b0);
    endtask

    task automatic csr_read(input logic [3:0] tst, input csr_addr_t addr);
        add_row(tst, 1'b1, 1'b0, OPC_RS, addr, '0, 1'b0, 1'b1);
    endtask

    // mstatus read with available low, must not load
    task automatic idle(input logic [3:0] tst, input logic ext);
        add_row(tst, 1'b0, 1'b0, OPC_RS, ADDR_MSTATUS, '0, ext, 1'b1);
    endtask

    task automatic build_table;
        csr_addr_t regs [3];
        int        k;
        regs[0] = ADDR_MIE;
        regs[1] = ADDR_MSTATUS;
        regs[2] = ADDR_MCAUSE;
        csr_read(0, ADDR_MSTATUS);
        csr_read(0, ADDR_MIE);
        csr_read(0, ADDR_MIP);
        for (k = 0; k < 3; k++) begin
            csr_op(1, OPC_RW, regs[k], rand_word());
            csr_read(1, regs[k]);
            csr_op(1, OPC_RS, regs[k], rand_word());
            csr_read(1, regs[k]);
            csr_op(1, OPC_RC, regs[k], rand_word());
            csr_read(1, regs[k]);
        end
        csr_op(2, OPC_RW, ADDR_MEPC, rand_word() | 32'h3);
        csr_read(2, ADDR_MEPC);
        csr_op(2, OPC_RS, ADDR_MEPC, 32'h3);
        csr_read(2, ADDR_MEPC);
        csr_op(2, OPC_RC, ADDR_MEPC, rand_word());
        csr_read(2, ADDR_MEPC);
        // MIE set and MPIE clear before the trap
        csr_op(3, OPC_RS, ADDR_MSTATUS, 32'h8);
        csr_op(3, OPC_RC, ADDR_MSTATUS, 32'h80);
        csr_op(3, OPC_EXC, 12'h015, rand_word());
        csr_read(3, ADDR_MEPC);
        csr_read(3, ADDR_MCAUSE);
        csr_read(3, ADDR_MSTATUS);
        csr_op(3, OPC_MRET, 12'h000, '0);
        csr_read(3, ADDR_MSTATUS);
        csr_op(4, OPC_RW, ADDR_MIE, 32'h808);
        csr_op(4, OPC_RS, ADDR_MSTATUS, 32'h8);
        csr_op(4, OPC_RC, ADDR_MIP, 32'h808);
        idle(4, 1'b1);
        idle(4, 1'b0);
        idle(4, 1'b0);
        csr_read(4, ADDR_MIP);
        csr_op(4, OPC_RC, ADDR_MIP, 32'h800);
        idle(4, 1'b0);
        csr_op(4, OPC_RS, ADDR_MIP, 32'h8);
        idle(4, 1'b0);
        idle(4, 1'b0);
        csr_op(4, OPC_EXC, 12'h013, rand_word());
        idle(4, 1'b0);
        csr_read(4, ADDR_MIP);
        add_row(5, 1'b1, 1'b0, OPC_RW, 12'h123, rand_word(), 1'b0, 1'b1);
        idle(5, 1'b0);
        add_row(5, 1'b1, 1'b1, OPC_RS, 12'h7c0, rand_word(), 1'b0, 1'b0);
        idle(5, 1'b0);
        add_row(5, 1'b1, 1'b0, 3'b010, ADDR_MIE, '0, 1'b0, 1'b1);
        idle(5, 1'b0);
        add_row(5, 1'b1, 1'b1, 3'b100, ADDR_MIE, '0, 1'b0, 1'b0);
        idle(5, 1'b0);
        add_row(5, 1'b1, 1'b0, OPC_NOP, ADDR_MSTATUS, '0, 1'b0, 1'b1);
        add_row(5, 1'b0, 1'b0, 3'b010, 12'h123, '0, 1'b0, 1'b1);
    endtask

    function automatic csr_data_t model_word(input csr_addr_t a);
        csr_data_t w;
        w = '0;
        if (a == ADDR_MSTATUS) begin
            w[BIT_MIE]  = m_mie;
            w[BIT_MPIE] = m_mpie;
        end else if (a == ADDR_MIE) begin
            w[BIT_EXT]  = m_meie;
            w[BIT_SOFT] = m_msie;
        end else if (a == ADDR_MEPC) begin
            w = m_mepc;
        end else if (a == ADDR_MCAUSE) begin
            w[BIT_INTR] = m_mcause_intr;
            w[3:0]      = m_code;
        end else if (a == ADDR_MIP) begin
            w[BIT_EXT]  = m_meip;
            w[BIT_SOFT] = m_msip;
        end
        return w;
    endfunction

    // state after one clock edge with this row applied
    task automatic model_step(input row_t r);
        logic       exc;
        logic       mret;
        logic       csr;
        logic       valid;
        logic       mapped;
        logic       rd;
        logic       wr;
        csr_data_t  set;
        csr_data_t  keep;
        logic [4:0] cause;
        exc    = (r.op == OPC_EXC);
        mret   = (r.op == OPC_MRET);
        csr    = (r.op == OPC_RW) || (r.op == OPC_RS) || (r.op == OPC_RC);
        valid  = exc || mret || csr || (r.op == OPC_NOP);
        mapped = (r.addr == ADDR_MSTATUS) || (r.addr == ADDR_MIE) || (r.addr == ADDR_MEPC) ||
                 (r.addr == ADDR_MCAUSE) || (r.addr == ADDR_MIP);
        rd     = r.avail && !r.wstage;
        wr     = r.avail && r.wstage;
        set    = (r.op == OPC_RC) ? '0 : r.wv;
        keep   = (r.op == OPC_RW) ? '0 : ((r.op == OPC_RS) ? '1 : ~r.wv);
        cause  = r.addr[4:0];
        m_fault    = r.avail && (!valid || (csr && !mapped));
        m_ext_pend = m_meip && m_meie && m_mie;
        m_sw_pend  = m_msip && m_msie && m_mie;
        if (rd && exc) begin
            m_rd    = HANDLER;
            m_saved = m_mie;
        end else if (rd && mret) begin
            m_rd    = m_mepc;
            m_saved = m_mpie;
        end else if (rd && csr && mapped) begin
            m_rd = model_word(r.addr);
        end
        if (wr && exc) begin
            m_mepc        = r.wv & ~32'h3;
            m_mcause_intr = cause[4];
            m_code        = cause[3:0];
            m_mpie        = m_saved;
            m_mie         = 1'b0;
            if (cause == CAUSE_SW_IRQ && m_msip) begin
                m_msip = 1'b0;
            end else if (cause == CAUSE_EXT_IRQ && m_meip) begin
                m_meip = 1'b0;
            end
        end
        if (wr && mret) begin
            m_mie = m_saved;
        end
        if (wr && csr && mapped) begin
            if (r.addr == ADDR_MSTATUS) begin
                m_mie  = set[BIT_MIE] | (keep[BIT_MIE] & m_mie);
                m_mpie = set[BIT_MPIE] | (keep[BIT_MPIE] & m_mpie);
            end else if (r.addr == ADDR_MIE) begin
                m_meie = set[BIT_EXT] | (keep[BIT_EXT] & m_meie);
                m_msie = set[BIT_SOFT] | (keep[BIT_SOFT] & m_msie);
            end else if (r.addr == ADDR_MEPC) begin
                m_mepc = (set | (keep & m_mepc)) & ~32'h3;
            end else if (r.addr == ADDR_MCAUSE) begin
                m_mcause_intr = set[BIT_INTR] | (keep[BIT_INTR] & m_mcause_intr);
                m_code        = set[3:0] | (keep[3:0] & m_code);
            end else begin
                m_meip = set[BIT_EXT] | (keep[BIT_EXT] & m_meip);
                m_msip = set[BIT_SOFT] | (keep[BIT_SOFT] & m_msip);
            end
        end
        if (r.ext) begin
            m_meip = 1'b1;
        end
    endtask

    task automatic drive_row(input row_t r);
        available_i      = r.avail;
        is_write_stage_i = r.wstage;
        op_i             = r.op;
        addr_exception_i = r.addr;
        write_value_i    = r.wv;
        ext_int_i        = r.ext;
    endtask

    task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("MISMATCH %s got %h expected %h (row %0d)", name, got, exp, cur_row);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("MISMATCH %s got %h expected %h (row %0d)", name, got, exp, cur_row);
        end
    endtask

    task automatic report_test(input int t);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", t, test_names[t]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", t, test_names[t], test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        reset_n_i        = 1'b0;
        available_i      = 1'b0;
        is_write_stage_i = 1'b0;
        ext_int_i        = 1'b0;
        op_i             = OPC_NOP;
        addr_exception_i = '0;
        write_value_i    = '0;
        lfsr = 32'h2e3e_bed1;
        n_rows       = 0;
        cur_row      = 0;
        errors       = 0;
        test_errors  = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_mie         = 1'b0;
        m_mpie        = 1'b0;
        m_saved       = 1'b0;
        m_mcause_intr = 1'b0;
        m_meie        = 1'b0;
        m_msie        = 1'b0;
        m_meip        = 1'b0;
        m_msip        = 1'b0;
        m_mepc        = '0;
        m_code        = '0;
        m_rd          = '0;
        m_fault       = 1'b0;
        m_ext_pend    = 1'b0;
        m_sw_pend     = 1'b0;
        test_names[0] = "reset";
        test_names[1] = "csr rw rs rc";
        test_names[2] = "mepc alignment";
        test_names[3] = "trap and mret";
        test_names[4] = "interrupts";
        test_names[5] = "faults";
        build_table();
        repeat (3) @(posedge clk_i);
        #1;
        reset_n_i = 1'b1;
        check_data("read_value_o", read_value_o, '0);
        check_bit("fault_o", fault_o, 1'b0);
        check_bit("ext_int_pending_o", ext_int_pending_o, 1'b0);
        check_bit("sw_int_pending_o", sw_int_pending_o, 1'b0);
        for (cur_row = 0; cur_row < n_rows; cur_row++) begin
            drive_row(table_q[cur_row]);
            model_step(table_q[cur_row]);
            table_q[cur_row].exp_rd    = m_rd;
            table_q[cur_row].exp_fault = m_fault;
            table_q[cur_row].exp_ext   = m_ext_pend;
            table_q[cur_row].exp_sw    = m_sw_pend;
            @(posedge clk_i);
            #1;
            if (table_q[cur_row].chk) begin
                check_data("read_value_o", read_value_o, table_q[cur_row].exp_rd);
            end
            check_bit("fault_o", fault_o, table_q[cur_row].exp_fault);
            check_bit("ext_int_pending_o", ext_int_pending_o, table_q[cur_row].exp_ext);
            check_bit("sw_int_pending_o", sw_int_pending_o, table_q[cur_row].exp_sw);
            if (cur_row == n_rows - 1 || table_q[cur_row + 1].tst != table_q[cur_row].tst) begin
                report_test(int'(table_q[cur_row].tst));
            end
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/csr_op_pkg.sv
logic/csr_map_pkg.sv
logic/csr_decode.sv
logic/csr_trap_state.sv
logic/csr_irq_state.sv
logic/csr_response.sv
logic/csr_top.sv
bench/tb_csr_top.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP      ?= tb_csr_top
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F -- '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
